// File: Bender.yml
package:
  name: ej32

sources:
  - files:
      - logic/ej32_pkg.sv
      - logic/ej32_apb_regs.sv
      - logic/ej32_cmd_fifo.sv
      - logic/ej32_div.sv
      - logic/ej32_core.sv
      - logic/ej32_top.sv
  - target: test
    files:
      - dv/ej32_tb.sv

// File: dv/ej32_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ej32 testbench, APB driven scenarios
// checked against a queue based stack model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ej32_tb;

    localparam int SS_DEPTH = 8;
    localparam int PERIOD   = 40;
    localparam int N_ARITH  = 200;
    localparam int N_DIV    = 40;
    localparam int N_CMDS   = N_ARITH * 5 + N_DIV * 5 + 120;   // pops to clear included

    logic            ctl;
    logic            div_rst;
    logic [3:0]      paddr;
    logic            psel;
    logic            penable;
    logic            pwrite;
    ej32_pkg::data_t pwdata;
    ej32_pkg::data_t prdata_o;
    logic            pready_o;
    logic            pslverr_o;

    integer          seed = 64970;
    int              errors = 0;
    int              stall_cnt = 0;
    ej32_pkg::data_t ref_stk[$];   // back is top of stack
    bit              ref_err = 1'b0;
    bit              ref_dbz = 1'b0;
    string           name_q[$];
    ej32_pkg::data_t got_q[$];
    ej32_pkg::data_t exp_q[$];

    ej32_pkg::opcode_t arith_ops[10] = '{ej32_pkg::OP_IADD, ej32_pkg::OP_ISUB,
        ej32_pkg::OP_IMUL, ej32_pkg::OP_IAND, ej32_pkg::OP_IOR, ej32_pkg::OP_IXOR,
        ej32_pkg::OP_ISHL, ej32_pkg::OP_ISHR, ej32_pkg::OP_IUSHR, ej32_pkg::OP_INEG};

    ej32_top #(.SS_DEPTH(SS_DEPTH), .FIFO_DEPTH(4)) ej32_top_i (
        .ctl(ctl), .div_rst(div_rst),
        .paddr_i(paddr), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .pwdata_i(pwdata), .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o)
    );

    initial begin
        ctl = 1'b0;
        forever #(PERIOD / 2) ctl = ~ctl;
    end

    // signed division, truncated toward zero
    function automatic ej32_pkg::data_t ref_div(ej32_pkg::data_t a, ej32_pkg::data_t b,
                                                bit want_rem);
        longint sa;
        longint sb;
        longint res;
        if (b == '0) return want_rem ? a : 32'hFFFF_FFFF;
        sa = $signed(a);
        sb = $signed(b);
        res = want_rem ? sa % sb : sa / sb;   // min / -1 wraps back to 0x80000000
        return res[31:0];
    endfunction

    function automatic void ref_exec(ej32_pkg::opcode_t op, ej32_pkg::data_t opd);
        ej32_pkg::data_t s;
        ej32_pkg::data_t t;
        ej32_pkg::data_t r;
        int              need;
        bit              grow;
        bit              known;
        need = 2;
        grow = 1'b0;
        known = 1'b1;
        case (op)
            ej32_pkg::OP_NOP:  need = 0;
            ej32_pkg::OP_LDI: begin
                need = 0;
                grow = 1'b1;
            end
            ej32_pkg::OP_DUP: begin
                need = 1;
                grow = 1'b1;
            end
            ej32_pkg::OP_POP, ej32_pkg::OP_INEG: need = 1;
            ej32_pkg::OP_SWAP, ej32_pkg::OP_IADD, ej32_pkg::OP_ISUB, ej32_pkg::OP_IMUL,
            ej32_pkg::OP_IDIV, ej32_pkg::OP_IREM, ej32_pkg::OP_ISHL, ej32_pkg::OP_ISHR,
            ej32_pkg::OP_IUSHR, ej32_pkg::OP_IAND, ej32_pkg::OP_IOR, ej32_pkg::OP_IXOR: ;
            default: known = 1'b0;
        endcase
        // dropped ops leave the stack as it was
        if (!known || ref_stk.size() < need || (grow && ref_stk.size() == SS_DEPTH)) begin
            ref_err = 1'b1;
            return;
        end
        if (need > 0) t = ref_stk.pop_back();
        if (need > 1) s = ref_stk.pop_back();
        r = t;
        case (op)
            ej32_pkg::OP_LDI:   r = opd;
            ej32_pkg::OP_DUP:   ref_stk.push_back(t);
            ej32_pkg::OP_SWAP: begin
                ref_stk.push_back(t);
                r = s;
            end
            ej32_pkg::OP_INEG:  r = -t;
            ej32_pkg::OP_IADD:  r = s + t;
            ej32_pkg::OP_ISUB:  r = s - t;   // second minus top
            ej32_pkg::OP_IMUL:  r = s * t;
            ej32_pkg::OP_IAND:  r = s & t;
            ej32_pkg::OP_IOR:   r = s | t;
            ej32_pkg::OP_IXOR:  r = s ^ t;
            ej32_pkg::OP_ISHL:  r = s << t[4:0];
            ej32_pkg::OP_ISHR:  r = $signed(s) >>> t[4:0];
            ej32_pkg::OP_IUSHR: r = s >> t[4:0];
            ej32_pkg::OP_IDIV:  r = ref_div(s, t, 1'b0);
            ej32_pkg::OP_IREM:  r = ref_div(s, t, 1'b1);
            default: ;
        endcase
        if ((op == ej32_pkg::OP_IDIV || op == ej32_pkg::OP_IREM) && t == '0) ref_dbz = 1'b1;
        if (op != ej32_pkg::OP_POP && op != ej32_pkg::OP_NOP) ref_stk.push_back(r);
    endfunction

    function automatic ej32_pkg::data_t ref_tos();
        return (ref_stk.size() == 0) ? '0 : ref_stk[$];
    endfunction

    function automatic ej32_pkg::data_t ref_status();
        ej32_pkg::data_t v;
        v = '0;
        v[ej32_pkg::ST_DBZ] = ref_dbz;
        v[ej32_pkg::ST_ERR] = ref_err;
        v[ej32_pkg::ST_DEPTH +: 8] = ref_stk.size();
        return v;
    endfunction

    task automatic check_val(string name, ej32_pkg::data_t got, ej32_pkg::data_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    // hands a result to the comparing process
    task automatic post_check(string name, ej32_pkg::data_t got, ej32_pkg::data_t exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    initial begin
        forever begin
            wait (exp_q.size() != 0);
            check_val(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
        end
    end

    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input ej32_pkg::data_t wd,
                            output ej32_pkg::data_t rd, output logic slverr);
        logic rdy;
        @(negedge ctl);
        paddr = addr;
        pwrite = wr;
        pwdata = wd;
        psel = 1'b1;
        penable = 1'b0;
        @(negedge ctl);
        penable = 1'b1;
        rdy = 1'b0;
        while (!rdy) begin
            #(PERIOD / 4);   // mid low phase, outputs settled
            rdy = pready_o;
            rd = prdata_o;
            slverr = pslverr_o;
            if (!rdy) stall_cnt++;
            @(negedge ctl);
        end
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(logic [3:0] addr, ej32_pkg::data_t wd);
        ej32_pkg::data_t rd;
        logic            se;
        apb_xfer(1'b1, addr, wd, rd, se);
        post_check("pslverr", se, 32'h0);
    endtask

    task automatic apb_read(input logic [3:0] addr, output ej32_pkg::data_t rd);
        logic se;
        apb_xfer(1'b0, addr, '0, rd, se);
        post_check("pslverr", se, 32'h0);
    endtask

    task automatic issue(ej32_pkg::opcode_t op, ej32_pkg::data_t opd);
        if (op == ej32_pkg::OP_LDI) apb_write(ej32_pkg::REG_OPERAND, opd);
        apb_write(ej32_pkg::REG_OPCODE, {24'h0, op});
        ref_exec(op, opd);
    endtask

    task automatic settle_and_check();
        ej32_pkg::data_t st;
        ej32_pkg::data_t tos;
        st = 32'h1;
        while (st[ej32_pkg::ST_BUSY]) apb_read(ej32_pkg::REG_STATUS, st);
        apb_read(ej32_pkg::REG_TOS, tos);
        post_check("tos", tos, ref_tos());
        post_check("status", st, ref_status());
    endtask

    task automatic clear_all();
        while (ref_stk.size() > 0) issue(ej32_pkg::OP_POP, '0);
        apb_write(ej32_pkg::REG_STATUS, '0);
        ref_err = 1'b0;
        ref_dbz = 1'b0;
    endtask

    initial begin
        repeat (N_CMDS * 40 + 1000) @(posedge ctl);
        $display("watchdog: the run timed out before the scenarios finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        ej32_pkg::data_t   a;
        ej32_pkg::data_t   b;
        ej32_pkg::data_t   rd;
        ej32_pkg::opcode_t op;
        logic              se;
        div_rst = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        repeat (5) @(posedge ctl);
        @(negedge ctl);
        div_rst = 1'b1;

        // reset state, then pop on an empty stack
        settle_and_check();
        issue(ej32_pkg::OP_POP, '0);
        settle_and_check();
        clear_all();
        issue(8'hFF, '0);   // not an opcode
        settle_and_check();
        clear_all();

        for (int i = 0; i < N_ARITH; i++) begin
            a = $random(seed);
            b = $random(seed);
            op = arith_ops[$unsigned($random(seed)) % 10];
            issue(ej32_pkg::OP_LDI, a);
            issue(ej32_pkg::OP_LDI, b);
            issue(op, '0);
            settle_and_check();
            clear_all();
        end

        // dup, swap, pop, then overflow
        issue(ej32_pkg::OP_LDI, 32'h5);
        issue(ej32_pkg::OP_LDI, 32'h9);
        issue(ej32_pkg::OP_SWAP, '0);
        issue(ej32_pkg::OP_DUP, '0);
        issue(ej32_pkg::OP_POP, '0);
        settle_and_check();
        for (int i = 0; i < SS_DEPTH; i++) issue(ej32_pkg::OP_LDI, i * 3 + 1);
        issue(ej32_pkg::OP_DUP, '0);
        settle_and_check();
        apb_write(ej32_pkg::REG_STATUS, '0);
        ref_err = 1'b0;
        issue(ej32_pkg::OP_SWAP, '0);
        settle_and_check();
        clear_all();

        for (int i = 0; i < N_DIV; i++) begin
            a = $random(seed);
            b = (i % 2) ? $random(seed) % 1000 : $random(seed);   // small divisors too
            issue(ej32_pkg::OP_LDI, a);
            issue(ej32_pkg::OP_LDI, b);
            issue((i % 3 == 0) ? ej32_pkg::OP_IREM : ej32_pkg::OP_IDIV, '0);
            settle_and_check();
            clear_all();
        end
        for (int i = 0; i < 4; i++) begin   // zero divisor and min by -1
            issue(ej32_pkg::OP_LDI, (i < 2) ? 32'hFFFF_FFB3 : 32'h8000_0000);
            issue(ej32_pkg::OP_LDI, (i < 2) ? 32'h0 : 32'hFFFF_FFFF);
            issue((i % 2) ? ej32_pkg::OP_IREM : ej32_pkg::OP_IDIV, '0);
            settle_and_check();
            clear_all();
        end

        // back-pressure behind a slow idiv
        issue(ej32_pkg::OP_LDI, 32'd1000);
        issue(ej32_pkg::OP_LDI, 32'd7);
        stall_cnt = 0;
        issue(ej32_pkg::OP_IDIV, '0);
        issue(ej32_pkg::OP_DUP, '0);
        issue(ej32_pkg::OP_DUP, '0);
        issue(ej32_pkg::OP_IADD, '0);
        issue(ej32_pkg::OP_DUP, '0);
        issue(ej32_pkg::OP_IMUL, '0);
        issue(ej32_pkg::OP_INEG, '0);
        post_check("stalled", stall_cnt > 0, 32'h1);
        settle_and_check();

        // illegal accesses change nothing
        apb_xfer(1'b1, ej32_pkg::REG_TOS, 32'hDEAD_BEEF, rd, se);
        post_check("pslverr", se, 32'h1);
        apb_xfer(1'b0, ej32_pkg::REG_OPCODE, '0, rd, se);
        post_check("pslverr", se, 32'h1);
        apb_read(ej32_pkg::REG_OPERAND, rd);
        post_check("operand", rd, 32'd7);   // last ldi operand
        settle_and_check();

        wait (exp_q.size() == 0);
        @(posedge ctl);
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: logic/ej32_apb_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ej32 APB register block
// operand latch, command push, TOS and status readback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ej32_apb_regs #(
    parameter int SS_DEPTH = 8
) (
    input  logic                         ctl,
    input  logic                         div_rst,
    input  logic [3:0]                   paddr_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  ej32_pkg::data_t              pwdata_i,
    output ej32_pkg::data_t              prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    output logic                         push_o,
    output ej32_pkg::cmd_t               push_data_o,
    input  logic                         full_i,
    input  logic                         empty_i,
    input  ej32_pkg::data_t              tos_i,
    input  logic [$clog2(SS_DEPTH):0]    depth_i,
    input  logic                         idle_i,
    input  logic                         dbz_i,
    input  logic                         err_i
);

    localparam int DEPTH_W = $clog2(SS_DEPTH) + 1;

    ej32_pkg::data_t operand_q;
    ej32_pkg::data_t status;
    logic            dbz_q;
    logic            err_q;
    logic            access;
    logic            wr_opc;
    logic            done;

    assign access = psel_i && penable_i;
    assign wr_opc = access && pwrite_i && (paddr_i == ej32_pkg::REG_OPCODE);

    // opcode writes wait here while the FIFO is full
    assign pready_o  = !(wr_opc && full_i);
    assign done      = access && pready_o;
    assign pslverr_o = access && ((pwrite_i && paddr_i == ej32_pkg::REG_TOS) ||
                                  (!pwrite_i && paddr_i == ej32_pkg::REG_OPCODE));

    assign push_o      = wr_opc && !full_i;
    assign push_data_o = {pwdata_i[7:0], operand_q};

    always_comb begin
        status = '0;
        status[ej32_pkg::ST_BUSY] = !empty_i || !idle_i;   // queued or running
        status[ej32_pkg::ST_DBZ]  = dbz_q;
        status[ej32_pkg::ST_ERR]  = err_q;
        status[ej32_pkg::ST_DEPTH +: DEPTH_W] = depth_i;
    end

    always_comb begin
        prdata_o = '0;
        if (psel_i && !pwrite_i) begin
            case (paddr_i)
                ej32_pkg::REG_OPERAND: prdata_o = operand_q;
                ej32_pkg::REG_TOS:     prdata_o = tos_i;
                ej32_pkg::REG_STATUS:  prdata_o = status;
                default:               prdata_o = '0;
            endcase
        end
    end

    always_ff @(posedge ctl) begin
        if (!div_rst) begin
            operand_q <= '0;
            dbz_q     <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            if (done && pwrite_i && paddr_i == ej32_pkg::REG_OPERAND) operand_q <= pwdata_i;
            if (done && pwrite_i && paddr_i == ej32_pkg::REG_STATUS) begin
                dbz_q <= 1'b0;
                err_q <= 1'b0;
            end
            // a new event wins over a clear in the same cycle
            if (dbz_i) dbz_q <= 1'b1;
            if (err_i) err_q <= 1'b1;
        end
    end

endmodule

// File: logic/ej32_cmd_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ej32 command FIFO, synchronous circular buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ej32_cmd_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic           ctl,
    input  logic           div_rst,
    input  logic           push_i,
    input  ej32_pkg::cmd_t push_data_i,
    input  logic           pop_i,
    output ej32_pkg::cmd_t pop_data_o,
    output logic           full_o,
    output logic           empty_o
);

    localparam int AW = $clog2(FIFO_DEPTH);

    ej32_pkg::cmd_t mem_q [FIFO_DEPTH];
    logic [AW:0]    wr_ptr_q;   // extra msb tells full from empty
    logic [AW:0]    rd_ptr_q;
    logic           wr_en;
    logic           rd_en;

    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                     (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

    assign wr_en = push_i && !full_o;
    assign rd_en = pop_i && !empty_o;

    assign pop_data_o = mem_q[rd_ptr_q[AW-1:0]];   // head word

    always_ff @(posedge ctl) begin
        if (wr_en) mem_q[wr_ptr_q[AW-1:0]] <= push_data_i;
    end

    always_ff @(posedge ctl) begin
        if (!div_rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

endmodule

// File: logic/ej32_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ej32 stack core
// dispatcher, data stack, ALU and divider control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ej32_core #(
    parameter int SS_DEPTH = 8
) (
    input  logic                      ctl,
    input  logic                      div_rst,
    input  logic                      empty_i,
    input  ej32_pkg::cmd_t            cmd_i,
    output logic                      pop_o,
    output ej32_pkg::data_t           tos_o,
    output logic [$clog2(SS_DEPTH):0] depth_o,
    output logic                      idle_o,
    output logic                      dbz_o,
    output logic                      err_o
);

    localparam int AW = $clog2(SS_DEPTH);

    typedef enum logic {C_FETCH, C_DIVWAIT} core_state_e;
    typedef enum logic [1:0] {SS_NONE, SS_PUSH, SS_POP, SS_MOVE} ss_op_e;

    core_state_e       state_q;
    ej32_pkg::opcode_t op_q;      // idiv or irem in flight
    ej32_pkg::data_t   tos_q;
    ej32_pkg::data_t   ss_q [SS_DEPTH];
    logic [AW:0]       depth_q;

    ej32_pkg::opcode_t op;
    ej32_pkg::data_t   opd;
    ej32_pkg::data_t   s;
    ej32_pkg::data_t   t_n;
    ss_op_e            ss_op;
    logic [1:0]        need;      // entries the op consumes
    logic              known;
    logic              is_div;
    logic              exec;
    logic              ok;
    logic              commit;
    logic [4:0]        sh;

    logic              div_start;
    logic              div_busy;
    logic              div_dbz;
    ej32_pkg::data_t   div_q;
    ej32_pkg::data_t   div_r;

    assign op   = cmd_i[39:32];
    assign opd  = cmd_i[31:0];
    assign s    = ss_q[AW'(depth_q - 2'd2)];   // next on stack
    assign sh   = tos_q[4:0];
    assign exec = (state_q == C_FETCH) && !empty_i;

    always_comb begin
        t_n    = tos_q;
        ss_op  = SS_NONE;
        need   = 2'd0;
        known  = 1'b1;
        is_div = 1'b0;
        if (state_q == C_DIVWAIT) begin
            t_n   = (op_q == ej32_pkg::OP_IDIV) ? div_q : div_r;
            ss_op = SS_POP;
        end else begin
            case (op)
                ej32_pkg::OP_NOP:   ;
                ej32_pkg::OP_LDI:   begin t_n = opd; ss_op = SS_PUSH; end
                ej32_pkg::OP_POP:   begin t_n = s; ss_op = SS_POP; need = 2'd1; end
                ej32_pkg::OP_DUP:   begin ss_op = SS_PUSH; need = 2'd1; end
                ej32_pkg::OP_SWAP:  begin t_n = s; ss_op = SS_MOVE; need = 2'd2; end
                ej32_pkg::OP_INEG:  begin t_n = -tos_q; need = 2'd1; end
                ej32_pkg::OP_IADD:  begin t_n = s + tos_q; ss_op = SS_POP; need = 2'd2; end
                ej32_pkg::OP_ISUB:  begin t_n = s - tos_q; ss_op = SS_POP; need = 2'd2; end
                ej32_pkg::OP_IMUL:  begin t_n = s * tos_q; ss_op = SS_POP; need = 2'd2; end
                ej32_pkg::OP_IAND:  begin t_n = s & tos_q; ss_op = SS_POP; need = 2'd2; end
                ej32_pkg::OP_IOR:   begin t_n = s | tos_q; ss_op = SS_POP; need = 2'd2; end
                ej32_pkg::OP_IXOR:  begin t_n = s ^ tos_q; ss_op = SS_POP; need = 2'd2; end
                ej32_pkg::OP_ISHL:  begin t_n = s << sh; ss_op = SS_POP; need = 2'd2; end
                ej32_pkg::OP_ISHR:  begin t_n = $signed(s) >>> sh; ss_op = SS_POP; need = 2'd2; end
                ej32_pkg::OP_IUSHR: begin t_n = s >> sh; ss_op = SS_POP; need = 2'd2; end
                ej32_pkg::OP_IDIV,
                ej32_pkg::OP_IREM:  begin is_div = 1'b1; need = 2'd2; end
                default:            known = 1'b0;
            endcase
        end
    end

    // drop anything the stack cannot serve
    assign ok = known && (depth_q >= need) &&
                !(ss_op == SS_PUSH && depth_q == SS_DEPTH);
    assign commit = (exec && ok && !is_div) || (state_q == C_DIVWAIT && !div_busy);
    assign div_start = exec && ok && is_div;

    assign pop_o   = exec;
    assign err_o   = exec && !ok;
    assign dbz_o   = (state_q == C_DIVWAIT) && !div_busy && div_dbz;
    assign idle_o  = (state_q == C_FETCH);
    assign depth_o = depth_q;
    assign tos_o   = (depth_q == '0) ? '0 : tos_q;

    always_ff @(posedge ctl) begin
        if (commit) begin
            tos_q <= t_n;
            if (ss_op == SS_PUSH) ss_q[AW'(depth_q - 1'b1)] <= tos_q;
            if (ss_op == SS_MOVE) ss_q[AW'(depth_q - 2'd2)] <= tos_q;   // swap
        end
        if (div_start) op_q <= op;
    end

    always_ff @(posedge ctl) begin
        if (!div_rst) begin
            state_q <= C_FETCH;
            depth_q <= '0;
        end else begin
            if (commit && ss_op == SS_PUSH) depth_q <= depth_q + 1'b1;
            if (commit && ss_op == SS_POP)  depth_q <= depth_q - 1'b1;
            if (div_start) state_q <= C_DIVWAIT;
            else if (state_q == C_DIVWAIT && !div_busy) state_q <= C_FETCH;
        end
    end

    ej32_div ej32_div_i (
        .ctl        (ctl),
        .div_rst    (div_rst),
        .start_i    (div_start),
        .dividend_i (s),
        .divisor_i  (tos_q),
        .busy_o     (div_busy),
        .quot_o     (div_q),
        .rem_o      (div_r),
        .dbz_o      (div_dbz)
    );

endmodule

// File: logic/ej32_div.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ej32 signed divider, 32-step restoring
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ej32_div (
    input  logic            ctl,
    input  logic            div_rst,
    input  logic            start_i,
    input  ej32_pkg::data_t dividend_i,
    input  ej32_pkg::data_t divisor_i,
    output logic            busy_o,
    output ej32_pkg::data_t quot_o,
    output ej32_pkg::data_t rem_o,
    output logic            dbz_o
);

    typedef enum logic [1:0] {DV_IDLE, DV_RUN, DV_FIX} div_state_e;

    div_state_e      state_q;
    logic [4:0]      cnt_q;
    ej32_pkg::data_t a_q;        // partial remainder
    ej32_pkg::data_t q_q;        // dividend shifts out, quotient shifts in
    ej32_pkg::data_t d_q;        // divisor magnitude
    logic            qneg_q;
    logic            rneg_q;
    logic            zero_q;
    logic [32:0]     shifted;
    logic [32:0]     diff;

    assign busy_o  = (state_q != DV_IDLE);
    assign shifted = {a_q, q_q[31]};
    assign diff    = shifted - {1'b0, d_q};   // msb set means borrow

    always_ff @(posedge ctl) begin
        if (!div_rst) begin
            state_q <= DV_IDLE;
            cnt_q   <= '0;
            dbz_o   <= 1'b0;
        end else begin
            case (state_q)
                DV_IDLE: if (start_i) begin
                    cnt_q   <= '0;
                    zero_q  <= (divisor_i == '0);
                    qneg_q  <= dividend_i[31] ^ divisor_i[31];
                    rneg_q  <= dividend_i[31];
                    d_q     <= divisor_i[31] ? -divisor_i : divisor_i;
                    // zero divisor keeps the raw dividend for the remainder
                    a_q     <= (divisor_i == '0) ? dividend_i : '0;
                    q_q     <= dividend_i[31] ? -dividend_i : dividend_i;
                    state_q <= (divisor_i == '0) ? DV_FIX : DV_RUN;
                end
                DV_RUN: begin
                    a_q     <= diff[32] ? shifted[31:0] : diff[31:0];
                    q_q     <= {q_q[30:0], !diff[32]};
                    cnt_q   <= cnt_q + 1'b1;
                    if (cnt_q == 5'd31) state_q <= DV_FIX;
                end
                default: begin   // sign fix-up
                    quot_o  <= zero_q ? '1 : (qneg_q ? -q_q : q_q);
                    rem_o   <= zero_q ? a_q : (rneg_q ? -a_q : a_q);
                    dbz_o   <= zero_q;
                    state_q <= DV_IDLE;
                end
            endcase
        end
    end

endmodule

// File: logic/ej32_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ej32 shared types, opcodes and APB register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ej32_pkg;

    typedef logic [31:0] data_t;     // stack word, operand, result
    typedef logic [7:0]  opcode_t;
    typedef logic [39:0] cmd_t;      // {opcode, operand}

    // JVM codes, except ldi which borrows 0x01
    localparam opcode_t OP_NOP   = 8'h00;
    localparam opcode_t OP_LDI   = 8'h01;
    localparam opcode_t OP_POP   = 8'h57;
    localparam opcode_t OP_DUP   = 8'h59;
    localparam opcode_t OP_SWAP  = 8'h5F;
    localparam opcode_t OP_IADD  = 8'h60;
    localparam opcode_t OP_ISUB  = 8'h64;
    localparam opcode_t OP_IMUL  = 8'h68;
    localparam opcode_t OP_IDIV  = 8'h6C;
    localparam opcode_t OP_IREM  = 8'h70;
    localparam opcode_t OP_INEG  = 8'h74;
    localparam opcode_t OP_ISHL  = 8'h78;
    localparam opcode_t OP_ISHR  = 8'h7A;
    localparam opcode_t OP_IUSHR = 8'h7C;
    localparam opcode_t OP_IAND  = 8'h7E;
    localparam opcode_t OP_IOR   = 8'h80;
    localparam opcode_t OP_IXOR  = 8'h82;

    // APB byte offsets
    localparam logic [3:0] REG_OPERAND = 4'h0;   // r/w operand latch
    localparam logic [3:0] REG_OPCODE  = 4'h4;   // write pushes a command
    localparam logic [3:0] REG_TOS     = 4'h8;   // read only
    localparam logic [3:0] REG_STATUS  = 4'hC;   // write clears sticky flags

    // status word layout
    localparam int unsigned ST_BUSY  = 0;
    localparam int unsigned ST_DBZ   = 1;
    localparam int unsigned ST_ERR   = 2;
    localparam int unsigned ST_DEPTH = 8;   // depth field starts here

endpackage

// File: logic/ej32_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ej32 arithmetic subsystem top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ej32_top #(
    parameter int SS_DEPTH   = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  logic            ctl,
    input  logic            div_rst,
    input  logic [3:0]      paddr_i,
    input  logic            psel_i,
    input  logic            penable_i,
    input  logic            pwrite_i,
    input  ej32_pkg::data_t pwdata_i,
    output ej32_pkg::data_t prdata_o,
    output logic            pready_o,
    output logic            pslverr_o
);

    logic                      push;
    ej32_pkg::cmd_t            push_data;
    logic                      full;
    logic                      empty;
    logic                      pop;
    ej32_pkg::cmd_t            head;
    ej32_pkg::data_t           tos;
    logic [$clog2(SS_DEPTH):0] depth;
    logic                      idle;
    logic                      dbz;
    logic                      err;

    ej32_apb_regs #(.SS_DEPTH(SS_DEPTH)) ej32_apb_regs_i (
        .ctl(ctl), .div_rst(div_rst),
        .paddr_i(paddr_i), .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .pwdata_i(pwdata_i), .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
        .push_o(push), .push_data_o(push_data), .full_i(full), .empty_i(empty),
        .tos_i(tos), .depth_i(depth), .idle_i(idle), .dbz_i(dbz), .err_i(err)
    );

    ej32_cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) ej32_cmd_fifo_i (
        .ctl(ctl), .div_rst(div_rst),
        .push_i(push), .push_data_i(push_data), .pop_i(pop),
        .pop_data_o(head), .full_o(full), .empty_o(empty)
    );

    ej32_core #(.SS_DEPTH(SS_DEPTH)) ej32_core_i (
        .ctl(ctl), .div_rst(div_rst), .empty_i(empty), .cmd_i(head),
        .pop_o(pop), .tos_o(tos), .depth_o(depth), .idle_o(idle), .dbz_o(dbz), .err_o(err)
    );

endmodule

// File: sim.f
logic/ej32_pkg.sv
logic/ej32_apb_regs.sv
logic/ej32_cmd_fifo.sv
logic/ej32_div.sv
logic/ej32_core.sv
logic/ej32_top.sv
dv/ej32_tb.sv
